// File: rtl/analog_pkg.sv
// Analog data path package with the shared sample widths, types and limits
`default_nettype none

package analog_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ADC_W     = 16;         // ADC word width
  localparam int DAC_W     = 14;         // DAC word width
  localparam int DAC_SUM_W = DAC_W + 1;  // One guard bit for the generator + controller sum

  ////////////////////
  // Sample types
  ////////////////////

  // Raw ADC word, offset binary with negative slope
  typedef logic [ADC_W-1:0] adc_raw_t;

  // Acquisition sample after conversion
  typedef logic signed [ADC_W-1:0] adc_smp_t;

  // Generator, controller and saturated DAC samples
  typedef logic signed [DAC_W-1:0] dac_smp_t;

  // Sum before saturation
  typedef logic signed [DAC_SUM_W-1:0] dac_sum_t;

  // Word sent to the converter, offset binary with negative slope
  typedef logic [DAC_W-1:0] dac_code_t;

  ////////////////////
  // DAC range limits
  ////////////////////

  localparam dac_smp_t DAC_MAX = {1'b0, {(DAC_W-1){1'b1}}};  // +8191
  localparam dac_smp_t DAC_MIN = {1'b1, {(DAC_W-1){1'b0}}};  // -8192

endpackage : analog_pkg

`default_nettype wire

// File: rtl/reset_sequencer.sv
// Reset sequencer holding the data path in reset for a fixed window after PLL lock
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
  parameter int unsigned RST_HOLD = 64   // Hold window in adc_clk cycles
) (
  input  logic adc_clk,
  input  logic reset_i,       // System reset, sync, active high
  input  logic pll_locked_i,  // Sampling clock PLL status
  output logic blk_rst_o      // Data path reset, active high
);

  // Counter must reach RST_HOLD itself
  localparam int CNT_W = $clog2(RST_HOLD + 1);

  logic             lock_q;     // Previous lock sample
  logic             lock_rise;  // Lock edge seen this cycle
  logic [CNT_W-1:0] hold_cnt;   // Zero means idle
  logic             hold_act;   // Window still open

  assign lock_rise = pll_locked_i & ~lock_q;
  assign hold_act  = |hold_cnt;

  ////////////////////
  // Lock edge detect
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      lock_q <= 1'b0;  // Lock already high at release counts as a fresh edge
    end else begin
      lock_q <= pll_locked_i;
    end
  end

  ////////////////////
  // Hold counter
  ////////////////////

  // Starts at the edge, runs 1..RST_HOLD then wraps to idle
  // Lost lock with an idle counter leaves it cleared
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      hold_cnt <= '0;
    end else if (lock_rise || hold_act) begin
      if (hold_cnt < CNT_W'(RST_HOLD)) begin
        hold_cnt <= hold_cnt + 1'b1;
      end else begin
        hold_cnt <= '0;  // Window done
      end
    end
  end

  // Merged block reset, one register stage
  always_ff @(posedge adc_clk) begin
    blk_rst_o <= reset_i | hold_act;
  end

endmodule : reset_sequencer

`default_nettype wire

// File: rtl/adc_frontend.sv
// ADC front end converting one channel's raw word to two's complement with loopback select
`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import analog_pkg::*;
(
  input  logic     adc_clk,
  input  logic     blk_rst_i,       // Data path reset
  input  adc_raw_t adc_raw_i,       // Raw converter word
  input  logic     digital_loop_i,  // Take the DAC sample instead
  input  dac_smp_t loop_smp_i,      // Saturated sample of this channel's DAC path
  output adc_smp_t adc_smp_o        // Acquisition sample
);

  adc_smp_t conv_smp;  // Converted ADC word
  adc_smp_t loop_ext;  // Loop sample in acquisition width

  // Negative slope offset binary -> two's complement
  // MSB kept, rest inverted
  assign conv_smp = {adc_raw_i[ADC_W-1], ~adc_raw_i[ADC_W-2:0]};

  // DAC sample sits in the low bits, upper bits zero as on the board
  assign loop_ext = {{(ADC_W-DAC_W){1'b0}}, loop_smp_i};

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge adc_clk) begin
    if (blk_rst_i) begin
      adc_smp_o <= '0;
    end else if (digital_loop_i) begin
      adc_smp_o <= loop_ext;  // Digital loopback
    end else begin
      adc_smp_o <= conv_smp;
    end
  end

endmodule : adc_frontend

`default_nettype wire

// File: rtl/dac_path.sv
// DAC path summing generator and controller samples with saturation and DAC encoding
`timescale 1ns/1ps
`default_nettype none

module dac_path
  import analog_pkg::*;
(
  input  logic      adc_clk,
  input  logic      blk_rst_i,   // Data path reset
  input  dac_smp_t  asg_smp_i,   // Generator sample
  input  dac_smp_t  pid_smp_i,   // Controller sample
  output dac_smp_t  sat_smp_o,   // Stage 1 result, also the loopback sample
  output dac_code_t dac_code_o   // Stage 2 result to the converter
);

  // Code for a zero sample, 14'h1FFF
  localparam dac_code_t CODE_ZERO = {1'b0, {(DAC_W-1){1'b1}}};

  dac_sum_t sum;      // Full precision sum
  logic     ovf;      // Sum outside 14 bit range
  dac_smp_t sat_smp;  // Clamped sum
  dac_code_t code;    // Encoded stage 1 value

  ////////////////////
  // Stage 1 sum and clamp
  ////////////////////

  // Both operands signed, so sign extended to the sum width
  assign sum = asg_smp_i + pid_smp_i;

  // Top two bits disagree -> result did not fit
  assign ovf = sum[DAC_SUM_W-1] ^ sum[DAC_SUM_W-2];

  always_comb begin
    if (ovf) begin
      sat_smp = sum[DAC_SUM_W-1] ? DAC_MIN : DAC_MAX;  // Sign picks the rail
    end else begin
      sat_smp = sum[DAC_W-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (blk_rst_i) begin
      sat_smp_o <= '0;
    end else begin
      sat_smp_o <= sat_smp;
    end
  end

  ////////////////////
  // Stage 2 encode
  ////////////////////

  // Sign bit kept, low 13 bits inverted
  // Gives negative slope offset binary for the converter
  assign code = {sat_smp_o[DAC_W-1], ~sat_smp_o[DAC_W-2:0]};

  always_ff @(posedge adc_clk) begin
    if (blk_rst_i) begin
      dac_code_o <= CODE_ZERO;  // Mid scale
    end else begin
      dac_code_o <= code;
    end
  end

endmodule : dac_path

`default_nettype wire

// File: rtl/analog_io_top.sv
// Analog I/O top with reset sequencing, two ADC front ends and two DAC paths
`timescale 1ns/1ps
`default_nettype none

module analog_io_top
  import analog_pkg::*;
#(
  parameter int unsigned RST_HOLD = 64   // Post lock hold window
) (
  input  logic      adc_clk,
  input  logic      reset_i,         // System reset, sync, active high
  input  logic      pll_locked_i,    // PLL lock status
  input  logic      digital_loop_i,  // Loopback both channels
  // ADC
  input  adc_raw_t  adc_a_i,         // CH A raw
  input  adc_raw_t  adc_b_i,         // CH B raw
  // Generator and controller samples
  input  dac_smp_t  asg_a_i,
  input  dac_smp_t  asg_b_i,
  input  dac_smp_t  pid_a_i,
  input  dac_smp_t  pid_b_i,
  // Outputs
  output logic      adc_rst_o,       // Data path reset
  output adc_smp_t  adc_a_o,         // CH A acquisition sample
  output adc_smp_t  adc_b_o,         // CH B acquisition sample
  output dac_code_t dac_a_o,         // CH A DAC code
  output dac_code_t dac_b_o          // CH B DAC code
);

  logic     blk_rst;  // Shared block reset
  dac_smp_t loop_a;   // CH A stage 1 sample back to the front end
  dac_smp_t loop_b;   // CH B stage 1 sample back to the front end

  assign adc_rst_o = blk_rst;

  ////////////////////
  // Reset
  ////////////////////

  reset_sequencer #(
    .RST_HOLD (RST_HOLD)
  ) rst_seq_i (
    .adc_clk      (adc_clk     ),
    .reset_i      (reset_i     ),
    .pll_locked_i (pll_locked_i),
    .blk_rst_o    (blk_rst     )
  );

  ////////////////////
  // Channel A
  ////////////////////

  adc_frontend adc_fe_a_i (
    .adc_clk        (adc_clk       ),
    .blk_rst_i      (blk_rst       ),
    .adc_raw_i      (adc_a_i       ),
    .digital_loop_i (digital_loop_i),
    .loop_smp_i     (loop_a        ),
    .adc_smp_o      (adc_a_o       )
  );

  dac_path dac_a_path_i (
    .adc_clk    (adc_clk),
    .blk_rst_i  (blk_rst),
    .asg_smp_i  (asg_a_i),
    .pid_smp_i  (pid_a_i),
    .sat_smp_o  (loop_a ),  // Loopback source
    .dac_code_o (dac_a_o)
  );

  ////////////////////
  // Channel B
  ////////////////////

  adc_frontend adc_fe_b_i (
    .adc_clk        (adc_clk       ),
    .blk_rst_i      (blk_rst       ),
    .adc_raw_i      (adc_b_i       ),
    .digital_loop_i (digital_loop_i),
    .loop_smp_i     (loop_b        ),
    .adc_smp_o      (adc_b_o       )
  );

  dac_path dac_b_path_i (
    .adc_clk    (adc_clk),
    .blk_rst_i  (blk_rst),
    .asg_smp_i  (asg_b_i),
    .pid_smp_i  (pid_b_i),
    .sat_smp_o  (loop_b ),  // Loopback source
    .dac_code_o (dac_b_o)
  );

endmodule : analog_io_top

`default_nettype wire

// File: bench/analog_ref.svh
// Testbench reference model, random source and value compare for the analog data path
`ifndef ANALOG_REF_SVH
`define ANALOG_REF_SVH

////////////////////
// Reference model
////////////////////

// Negative slope offset binary where raw 0 is full positive
function automatic int adc_convert(input adc_raw_t raw);
  return 32767 - int'(raw);
endfunction

// Generator + controller clamped to the 14 bit range
function automatic int saturate(input dac_smp_t a, input dac_smp_t b);
  int s;
  int top;
  top = (1 << (DAC_W - 1)) - 1;  // +8191
  s   = int'(a) + int'(b);
  if (s > top) begin
    s = top;
  end else if (s < -top - 1) begin
    s = -top - 1;
  end
  return s;
endfunction

// Zero maps to mid scale and positive full scale to code 0
function automatic int dac_encode(input int s);
  return (1 << (DAC_W - 1)) - 1 - s;
endfunction

////////////////////
// Random source
////////////////////

// Galois step shifting right
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

////////////////////
// Compare
////////////////////

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
  if (got !== want) begin
    $display("error: %s = %h, expected %h", name, got, want);
    $display("Done: errors found");
    $fatal(1, "first mismatch");
  end
endtask

`endif

// File: bench/analog_tb.sv
// Testbench for the analog I/O top covering reset sequencing, ADC conversion, DAC sums and loopback
`timescale 1ns/1ps
`default_nettype none

module analog_tb
  import analog_pkg::*;
;

  localparam int RST_HOLD_TB = 16;  // Short hold window
  localparam int MODE_SMALL  = 0;   // Sums that fit
  localparam int MODE_RAIL   = 1;   // Same sign near full scale
  localparam int MODE_FULL   = 2;   // Any 14 bit value

  logic      adc_clk = 1'b0;
  logic      reset_i;
  logic      pll_locked_i;
  logic      digital_loop_i;
  adc_raw_t  adc_a_i, adc_b_i;
  dac_smp_t  asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  logic      adc_rst_o;
  adc_smp_t  adc_a_o, adc_b_o;
  dac_code_t dac_a_o, dac_b_o;

  logic [31:0] lfsr_state;
  logic        data_chk;         // Data checks armed
  int          conv_a_q, conv_b_q;
  int          sat_a_d [2];      // Expected saturated sums two deep
  int          sat_b_d [2];
  logic        loop_q;
  logic [1:0]  vld_d = 2'b00;

  `include "analog_ref.svh"

  analog_io_top #(
    .RST_HOLD (RST_HOLD_TB)
  ) dut_i (
    .adc_clk        (adc_clk       ),
    .reset_i        (reset_i       ),
    .pll_locked_i   (pll_locked_i  ),
    .digital_loop_i (digital_loop_i),
    .adc_a_i        (adc_a_i       ),
    .adc_b_i        (adc_b_i       ),
    .asg_a_i        (asg_a_i       ),
    .asg_b_i        (asg_b_i       ),
    .pid_a_i        (pid_a_i       ),
    .pid_b_i        (pid_b_i       ),
    .adc_rst_o      (adc_rst_o     ),
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       ),
    .dac_a_o        (dac_a_o       ),
    .dac_b_o        (dac_b_o       )
  );

  initial begin
    forever #4 adc_clk = ~adc_clk;  // 8 ns
  end

  ////////////////////
  // Compare process
  ////////////////////

  // Inputs captured at the rising edge and outputs read at the falling edge
  always begin
    @(posedge adc_clk);
    sat_a_d[1] = sat_a_d[0];
    sat_b_d[1] = sat_b_d[0];
    sat_a_d[0] = saturate(asg_a_i, pid_a_i);
    sat_b_d[0] = saturate(asg_b_i, pid_b_i);
    conv_a_q   = adc_convert(adc_a_i);
    conv_b_q   = adc_convert(adc_b_i);
    loop_q     = digital_loop_i;
    vld_d      = {vld_d[0], data_chk};
    @(negedge adc_clk);
    if (vld_d[0] && !loop_q) begin  // One cycle ADC latency
      check_value("adc_a_o", 32'(adc_a_o), conv_a_q);
      check_value("adc_b_o", 32'(adc_b_o), conv_b_q);
    end
    if (vld_d[0] && loop_q && vld_d[1]) begin  // Loop sample with two zero bits on top
      check_value("adc_a_o", 32'(adc_a_o), sat_a_d[1] & ((1 << DAC_W) - 1));
      check_value("adc_b_o", 32'(adc_b_o), sat_b_d[1] & ((1 << DAC_W) - 1));
    end
    if (vld_d[1]) begin  // Two cycle DAC latency
      check_value("dac_a_o", 32'(dac_a_o), dac_encode(sat_a_d[1]));
      check_value("dac_b_o", 32'(dac_b_o), dac_encode(sat_b_d[1]));
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic dac_smp_t draw_sample(input int mode, input logic sgn);
    logic [12:0] half;
    logic [9:0]  off;
    dac_smp_t    smp;
    if (mode == MODE_SMALL) begin
      half = 13'(take_bits(13));
      smp  = {half[12], half};  // Sign extended so the sum cannot overflow
    end else if (mode == MODE_RAIL) begin
      off = 10'(take_bits(10));
      smp = dac_smp_t'(sgn ? (-8192 + int'(off)) : (8191 - int'(off)));
    end else begin
      smp = dac_smp_t'(take_bits(DAC_W));
    end
    return smp;
  endfunction

  task automatic drive_inputs(input int mode);
    logic sgn_a, sgn_b;
    sgn_a   = take_bits(1) != 0;
    sgn_b   = take_bits(1) != 0;
    adc_a_i = adc_raw_t'(take_bits(ADC_W));
    adc_b_i = adc_raw_t'(take_bits(ADC_W));
    asg_a_i = draw_sample(mode, sgn_a);
    pid_a_i = draw_sample(mode, sgn_a);  // Same sign per channel
    asg_b_i = draw_sample(mode, sgn_b);
    pid_b_i = draw_sample(mode, sgn_b);
  endtask

  task automatic run_cycles(input int n, input int mode);
    data_chk = 1'b1;
    repeat (n) begin
      drive_inputs(mode);
      @(negedge adc_clk);
    end
  endtask

  task automatic check_held_outputs();
    check_value("adc_a_o", 32'(adc_a_o), 0);
    check_value("adc_b_o", 32'(adc_b_o), 0);
    check_value("dac_a_o", 32'(dac_a_o), dac_encode(0));  // Mid scale
    check_value("dac_b_o", 32'(dac_b_o), dac_encode(0));
  endtask

  task automatic wait_rst_low(input string what, input int limit);
    int t;
    t = 0;
    while (adc_rst_o !== 1'b0 && t < limit) begin
      @(negedge adc_clk);
      t++;
    end
    if (adc_rst_o !== 1'b0) begin
      $display("timeout: adc_rst_o did not fall during %s", what);
      $display("Done: errors found");
      $fatal(1, "wait expired");
    end
  endtask

  // Raise lock and measure the hold window
  task automatic lock_window();
    int hi_cnt;
    hi_cnt       = 0;
    pll_locked_i = 1'b1;
    @(negedge adc_clk);  // Lock sampled but reset not yet out
    check_value("adc_rst_o", 32'(adc_rst_o), 0);
    @(negedge adc_clk);  // Second edge after lock
    check_value("adc_rst_o", 32'(adc_rst_o), 1);
    while (adc_rst_o === 1'b1 && hi_cnt < 4 * RST_HOLD_TB) begin
      hi_cnt++;
      @(negedge adc_clk);
      if (adc_rst_o === 1'b1) begin
        check_held_outputs();
      end
    end
    wait_rst_low("the lock hold window", 1);
    check_value("adc_rst_o high cycles", hi_cnt, RST_HOLD_TB);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    reset_i        = 1'b1;
    pll_locked_i   = 1'b0;
    digital_loop_i = 1'b0;
    adc_a_i        = '0;
    adc_b_i        = '0;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    data_chk       = 1'b0;
    lfsr_state     = 32'h6920;
    repeat (10) @(negedge adc_clk);
    check_value("adc_rst_o", 32'(adc_rst_o), 1);
    check_held_outputs();
    reset_i = 1'b0;
    wait_rst_low("release of reset_i", 8);
    repeat (3) @(negedge adc_clk);
    lock_window();                   // Lock after reset
    run_cycles(200, MODE_SMALL);     // Conversion and plain sums
    run_cycles(100, MODE_RAIL);      // Both rails
    digital_loop_i = 1'b1;
    run_cycles(100, MODE_FULL);      // Loopback
    digital_loop_i = 1'b0;
    run_cycles(20, MODE_FULL);
    data_chk     = 1'b0;             // Lock lost mid run
    pll_locked_i = 1'b0;
    repeat (5) @(negedge adc_clk);
    check_value("adc_rst_o", 32'(adc_rst_o), 0);
    lock_window();
    run_cycles(100, MODE_SMALL);
    data_chk = 1'b0;
    repeat (3) @(negedge adc_clk);
    $display("Done: no errors");
    $finish;
  end

endmodule : analog_tb

`default_nettype wire

// File: filelist.f
+incdir+bench
rtl/analog_pkg.sv
rtl/reset_sequencer.sv
rtl/adc_frontend.sv
rtl/dac_path.sv
rtl/analog_io_top.sv
bench/analog_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the analog data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module analog_tb \
  -f filelist.f -Mdir obj_dir -o analog_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/analog_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0
